// ==== verilog.f ====
cnn_pkg.sv
top_control.sv
kernel_buffer.sv
winograd_pe.sv
pool_unit.sv
hwcnn_top.sv
hwcnn_assert.sv
hwcnn_tb.sv

// ==== Bender.yml ====
package:
  name: hwcnn

sources:
  - cnn_pkg.sv
  - top_control.sv
  - kernel_buffer.sv
  - winograd_pe.sv
  - pool_unit.sv
  - hwcnn_top.sv
  - target: test
    files:
      - hwcnn_assert.sv
      - hwcnn_tb.sv

// ==== hwcnn_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hwcnn_tb;

	import cnn_pkg::*;

	localparam int NUM_TESTS = 5;
	localparam int FEAT_BITS = LANES*TILE_IN*FEAT_W;
	localparam int RAW_BITS  = LANES*TILE_OUT*RESULT_W;
	localparam int POOL_BITS = LANES*RESULT_W;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic [INST_W-1:0]    inst;
	logic                 inst_empty;
	logic                 inst_req;
	logic [FEAT_BITS-1:0] feature;
	logic                 feature_valid;
	logic [RAW_BITS-1:0]  result_raw;
	logic [POOL_BITS-1:0] result_pool;
	logic                 result_valid;

	logic [INST_W-1:0]    fifo_q [$];
	logic [RAW_BITS-1:0]  exp_raw_q [$];
	logic [POOL_BITS-1:0] exp_pool_q [$];
	logic                 req_seen = 1'b0;
	int                   pops = 0;
	string                test_name = "none";

	// Reference copy of what the DUT should hold
	int    g [LANES][KER_LEN];
	int    bias [LANES];
	int    shift = 0;
	pool_e pool = POOL_MAX;

	hwcnn_top UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.inst         (inst),
		.inst_empty   (inst_empty),
		.inst_req     (inst_req),
		.feature      (feature),
		.feature_valid(feature_valid),
		.result_raw   (result_raw),
		.result_pool  (result_pool),
		.result_valid (result_valid)
	);

	always #10 clk = ~clk;

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// Instruction FIFO, popped word shows up one cycle after inst_req
	always @(posedge clk) begin
		#2;
		if (req_seen) begin
			inst = fifo_q.pop_front();
			pops++;
		end
		req_seen   = inst_req;
		inst_empty = (fifo_q.size() == 0);
	end

	////////////////////////////////////////////////////////////
	// Reference model, direct 3-tap dot product
	////////////////////////////////////////////////////////////
	function automatic void model_tile(input logic [FEAT_BITS-1:0] f,
		output logic [RAW_BITS-1:0] raw, output logic [POOL_BITS-1:0] pooled);
		longint d [TILE_IN];
		longint y [TILE_OUT];
		longint b;
		longint p;
		for (int l = 0; l < LANES; l++) begin
			for (int k = 0; k < TILE_IN; k++)
				d[k] = longint'($signed(f[(l*TILE_IN + k)*FEAT_W +: FEAT_W]));
			b = longint'(bias[l]) <<< shift;
			for (int j = 0; j < TILE_OUT; j++) begin
				y[j] = d[j]*g[l][0] + d[j+1]*g[l][1] + d[j+2]*g[l][2] + b;
				y[j] = longint'($signed(y[j][RESULT_W-1:0]));  // Wrap to result width
				raw[(l*TILE_OUT + j)*RESULT_W +: RESULT_W] = y[j][RESULT_W-1:0];
			end
			if (pool == POOL_AVG)
				p = (y[0] + y[1]) >>> 1;  // Floor
			else
				p = (y[0] > y[1]) ? y[0] : y[1];
			pooled[l*RESULT_W +: RESULT_W] = p[RESULT_W-1:0];
		end
	endfunction

	function automatic int rand_signed(input int bits);
		int r;
		r = $urandom;
		return (r <<< (32 - bits)) >>> (32 - bits);
	endfunction

	// Scoreboard, sampled mid-cycle
	always @(negedge clk) begin : check_results
		logic [RAW_BITS-1:0]  exp_raw;
		logic [POOL_BITS-1:0] exp_pool;
		assert (UUT.hwcnn_chk.fail_count == 0) else begin
			$display("A protocol assertion failed in %s", test_name);
			stop_run();
		end
		if (rst_n && result_valid) begin
			assert (exp_raw_q.size() > 0) else begin
				$display("result_valid rose with no tile in flight in %s", test_name);
				stop_run();
			end
			exp_raw  = exp_raw_q.pop_front();
			exp_pool = exp_pool_q.pop_front();
			assert (result_raw === exp_raw) else begin
				$display("error %s raw expected %h actual %h", test_name, exp_raw, result_raw);
				stop_run();
			end
			assert (result_pool === exp_pool) else begin
				$display("error %s pool expected %h actual %h", test_name, exp_pool,
					result_pool);
				stop_run();
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////
	task automatic load_kernel(input int lane, input int g0, input int g1, input int g2,
		input int b);
		logic [INST_W-1:0] w;
		w                        = '0;
		w[OP_LSB +: OP_W]        = OP_LOAD_KERNEL;
		w[LANE_LSB +: 4]         = lane[3:0];
		w[TAP_LSB +: 8]          = g0[7:0];
		w[TAP_LSB + 8 +: 8]      = g1[7:0];
		w[TAP_LSB + 16 +: 8]     = g2[7:0];
		w[BIAS_LSB +: BIAS_W]    = b[BIAS_W-1:0];
		fifo_q.push_back(w);
		g[lane] = '{g0, g1, g2};
		bias[lane] = b;
	endtask

	task automatic set_mode(input pool_e p, input int s);
		logic [INST_W-1:0] w;
		w                       = '0;
		w[OP_LSB +: OP_W]       = OP_SET_MODE;
		w[POOL_BIT]             = p;
		w[SHIFT_LSB +: SHIFT_W] = s[SHIFT_W-1:0];
		fifo_q.push_back(w);
		pool  = p;
		shift = s;
	endtask

	task automatic load_random_kernels(input logic neg_bias);
		for (int l = 0; l < LANES; l++)
			load_kernel(l, rand_signed(8), rand_signed(8), rand_signed(8),
				neg_bias ? -(1 + $urandom % 50000) : rand_signed(BIAS_W));
	endtask

	// Last pop plus four cycles before features go out
	task automatic drain_fifo();
		while (fifo_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
		repeat (4) @(posedge clk);
		#2;
	endtask

	task automatic send_tile(input logic [FEAT_BITS-1:0] f);
		logic [RAW_BITS-1:0]  raw;
		logic [POOL_BITS-1:0] pooled;
		model_tile(f, raw, pooled);
		exp_raw_q.push_back(raw);
		exp_pool_q.push_back(pooled);
		feature       = f;
		feature_valid = 1'b1;
		@(posedge clk);
		#2;
		feature_valid = 1'b0;
	endtask

	task automatic wait_results();
		while (exp_raw_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic test_reset();
		test_name = "test_reset";
		assert (inst_req === 1'b0 && result_valid === 1'b0) else begin
			$display("inst_req or result_valid not low after reset");
			stop_run();
		end
		repeat (20) begin
			@(posedge clk);
			#2;
			assert (inst_req === 1'b0) else begin
				$display("inst_req pulsed while the FIFO was empty");
				stop_run();
			end
		end
	endtask

	task automatic test_single_tile();
		test_name = "test_single_tile";
		load_random_kernels(1'b0);
		set_mode(POOL_MAX, 0);
		drain_fifo();
		send_tile({$urandom, $urandom, $urandom, $urandom});
		repeat (2) @(posedge clk);
		#2;
		assert (result_valid === 1'b0) else begin
			$display("result_valid came early in %s", test_name);
			stop_run();
		end
		@(posedge clk);
		#2;
		assert (result_valid === 1'b1) else begin
			$display("result_valid missing 4 cycles after the tile in %s", test_name);
			stop_run();
		end
		wait_results();
	endtask

	task automatic test_stream();
		test_name = "test_stream";
		load_random_kernels(1'b0);
		set_mode(pool_e'($urandom % 2), $urandom % 4);
		drain_fifo();
		repeat (32)
			send_tile({$urandom, $urandom, $urandom, $urandom});  // Back to back
		wait_results();
	endtask

	task automatic test_avg_shift();
		test_name = "test_avg_shift";
		load_random_kernels(1'b1);
		set_mode(POOL_AVG, 3);
		drain_fifo();
		repeat (8)
			send_tile({$urandom, $urandom, $urandom, $urandom});
		wait_results();
	endtask

	task automatic test_ignored_ops();
		int pops_start;
		test_name  = "test_ignored_ops";
		pops_start = pops;
		fifo_q.push_back({4'h0, 4'd0, 24'($urandom), 32'($urandom)});
		fifo_q.push_back({4'hf, 4'd1, 24'($urandom), 32'($urandom)});
		load_kernel(2, rand_signed(8), rand_signed(8), rand_signed(8), rand_signed(BIAS_W));
		fifo_q.push_back({4'h7, 4'd3, 24'($urandom), 32'($urandom)});  // Looks like a load
		fifo_q.push_back({4'h0, 4'd2, 24'($urandom), 32'($urandom)});
		// Five words at three cycles each, plus FIFO pickup
		repeat (16) @(posedge clk);
		#2;
		assert (pops - pops_start == 5) else begin
			$display("error %s pops expected 5 actual %0d", test_name, pops - pops_start);
			stop_run();
		end
		drain_fifo();
		repeat (4)
			send_tile({$urandom, $urandom, $urandom, $urandom});
		wait_results();
	endtask

	// Watchdog
	initial begin
		repeat (NUM_TESTS*400 + 1000) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		stop_run();
	end

	initial begin
		void'($urandom(32'hc30));
		rst_n         = 1'b0;
		inst          = '0;
		inst_empty    = 1'b1;
		feature       = '0;
		feature_valid = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset();
		test_single_tile();
		test_stream();
		test_avg_shift();
		test_ignored_ops();
		repeat (2) @(posedge clk);
		if (UUT.hwcnn_chk.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("%0d protocol assertions failed", UUT.hwcnn_chk.fail_count);
			stop_run();
		end
	end

endmodule

`default_nettype wire

// ==== hwcnn_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module hwcnn_assert (
	input logic clk,
	input logic rst_n,
	input logic inst_req,
	input logic inst_empty,
	input logic feature_valid,
	input logic result_valid
);

	int fail_count = 0;

	// Pop only from a nonempty FIFO
	req_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
		inst_req |-> !inst_empty)
	else begin
		fail_count++;
		$error("inst_req while the instruction FIFO is empty");
	end

	req_single: assert property (@(posedge clk) disable iff (!rst_n)
		inst_req |=> !inst_req)
	else begin
		fail_count++;
		$error("inst_req high for two cycles in a row");
	end

	// Fixed datapath latency
	valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid == $past(feature_valid, 4))
	else begin
		fail_count++;
		$error("result_valid is not feature_valid delayed by 4 cycles");
	end

endmodule

bind hwcnn_top hwcnn_assert hwcnn_chk (
	.clk          (clk),
	.rst_n        (rst_n),
	.inst_req     (inst_req),
	.inst_empty   (inst_empty),
	.feature_valid(feature_valid),
	.result_valid (result_valid)
);

`default_nettype wire

// ==== hwcnn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hwcnn_top (
	input  logic                                                          clk,
	input  logic                                                          rst_n,
	input  logic [cnn_pkg::INST_W-1:0]                                    inst,
	input  logic                                                          inst_empty,
	output logic                                                          inst_req,
	input  logic [cnn_pkg::LANES*cnn_pkg::TILE_IN*cnn_pkg::FEAT_W-1:0]    feature,
	input  logic                                                          feature_valid,
	output logic [cnn_pkg::LANES*cnn_pkg::TILE_OUT*cnn_pkg::RESULT_W-1:0] result_raw,
	output logic [cnn_pkg::LANES*cnn_pkg::RESULT_W-1:0]                   result_pool,
	output logic                                                          result_valid
);

	import cnn_pkg::*;

	// Controller to kernel store
	logic                           kernel_we;
	logic [LANE_IDX_W-1:0]          kernel_lane;
	logic [KER_LEN*WEIGHT_W-1:0]    kernel_taps;
	logic [BIAS_W-1:0]              kernel_bias;
	logic [SHIFT_W-1:0]             bias_shift;
	pool_e                          pool_type;

	// Kernel store to lanes, lanes to pooling
	logic [LANES*TILE_IN*TWEIGHT_W-1:0] tweights;
	logic [LANES*RESULT_W-1:0]          bias_ext;
	logic [LANES*TILE_OUT*RESULT_W-1:0] lane_out;
	logic [LANES-1:0]                   lane_valid;

	top_control tctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.inst_empty (inst_empty),
		.inst_req   (inst_req),
		.kernel_we  (kernel_we),
		.kernel_lane(kernel_lane),
		.kernel_taps(kernel_taps),
		.kernel_bias(kernel_bias),
		.bias_shift (bias_shift),
		.pool_type  (pool_type)
	);

	kernel_buffer kbuf (
		.clk        (clk),
		.rst_n      (rst_n),
		.kernel_we  (kernel_we),
		.kernel_lane(kernel_lane),
		.kernel_taps(kernel_taps),
		.kernel_bias(kernel_bias),
		.bias_shift (bias_shift),
		.tweights   (tweights),
		.bias_ext   (bias_ext)
	);

	////////////////////////////////////////////////////////////
	// Processing lanes
	////////////////////////////////////////////////////////////
	for (genvar l = 0; l < LANES; l++) begin : g_lane
		winograd_pe pe (
			.clk          (clk),
			.rst_n        (rst_n),
			.feature_valid(feature_valid),  // Same strobe for every lane
			.tile         (feature[l*TILE_IN*FEAT_W +: TILE_IN*FEAT_W]),
			.tweights     (tweights[l*TILE_IN*TWEIGHT_W +: TILE_IN*TWEIGHT_W]),
			.bias_ext     (bias_ext[l*RESULT_W +: RESULT_W]),
			.out_valid    (lane_valid[l]),
			.outs         (lane_out[l*TILE_OUT*RESULT_W +: TILE_OUT*RESULT_W])
		);
	end

	pool_unit pool (
		.clk         (clk),
		.rst_n       (rst_n),
		.lane_valid  (lane_valid),
		.lane_out    (lane_out),
		.pool_type   (pool_type),
		.result_valid(result_valid),
		.result_raw  (result_raw),
		.result_pool (result_pool)
	);

endmodule

`default_nettype wire

// ==== pool_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pool_unit (
	input  logic                                                          clk,
	input  logic                                                          rst_n,
	input  logic [cnn_pkg::LANES-1:0]                                     lane_valid,
	input  logic [cnn_pkg::LANES*cnn_pkg::TILE_OUT*cnn_pkg::RESULT_W-1:0] lane_out,
	input  cnn_pkg::pool_e                                                pool_type,
	output logic                                                          result_valid,
	output logic [cnn_pkg::LANES*cnn_pkg::TILE_OUT*cnn_pkg::RESULT_W-1:0] result_raw,
	output logic [cnn_pkg::LANES*cnn_pkg::RESULT_W-1:0]                   result_pool
);

	import cnn_pkg::*;

	logic signed [RESULT_W-1:0] a [LANES];
	logic signed [RESULT_W-1:0] b [LANES];
	logic signed [RESULT_W-1:0] pooled [LANES];
	logic signed [RESULT_W:0]   pair_sum [LANES];  // One guard bit

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			a[l]        = lane_out[(l*TILE_OUT)*RESULT_W +: RESULT_W];
			b[l]        = lane_out[(l*TILE_OUT + 1)*RESULT_W +: RESULT_W];
			pair_sum[l] = a[l] + b[l];
			if (pool_type == POOL_AVG)
				pooled[l] = RESULT_W'(pair_sum[l] >>> 1);  // Floor average
			else
				pooled[l] = (a[l] > b[l]) ? a[l] : b[l];
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++) begin
			if (lane_valid[l]) begin
				result_raw[l*TILE_OUT*RESULT_W +: TILE_OUT*RESULT_W] <=
					lane_out[l*TILE_OUT*RESULT_W +: TILE_OUT*RESULT_W];
				result_pool[l*RESULT_W +: RESULT_W] <= pooled[l];
			end
		end
	end

	// Lanes run in lockstep
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			result_valid <= 1'b0;
		else
			result_valid <= lane_valid[0];
	end

endmodule

`default_nettype wire

// ==== winograd_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module winograd_pe (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            feature_valid,
	input  logic [cnn_pkg::TILE_IN*cnn_pkg::FEAT_W-1:0]     tile,
	input  logic [cnn_pkg::TILE_IN*cnn_pkg::TWEIGHT_W-1:0]  tweights,
	input  logic [cnn_pkg::RESULT_W-1:0]                    bias_ext,
	output logic                                            out_valid,
	output logic [cnn_pkg::TILE_OUT*cnn_pkg::RESULT_W-1:0]  outs
);

	import cnn_pkg::*;

	logic signed [FEAT_W-1:0]           d [TILE_IN];
	logic signed [TWEIGHT_W-1:0]        u [TILE_IN];
	logic signed [FEAT_W:0]             v [TILE_IN];  // Transformed input
	logic signed [FEAT_W+TWEIGHT_W:0]   m [TILE_IN];  // Element products
	logic signed [FEAT_W+TWEIGHT_W+2:0] s0, s1;       // Twice the outputs
	logic signed [RESULT_W-1:0]         y0, y1;
	logic [PE_LATENCY-1:0]              vld;          // One bit per stage

	always_comb begin
		for (int k = 0; k < TILE_IN; k++) begin
			d[k] = tile[k*FEAT_W +: FEAT_W];
			u[k] = tweights[k*TWEIGHT_W +: TWEIGHT_W];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vld <= '0;
		else
			vld <= {vld[PE_LATENCY-2:0], feature_valid};
	end

	////////////////////////////////////////////////////////////
	// Stage 1, input transform B^T d
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (feature_valid) begin
			v[0] <= d[0] - d[2];
			v[1] <= d[1] + d[2];
			v[2] <= d[2] - d[1];
			v[3] <= d[1] - d[3];
		end
	end

	// Stage 2, elementwise multiply
	always_ff @(posedge clk) begin
		if (vld[0]) begin
			for (int k = 0; k < TILE_IN; k++)
				m[k] <= v[k] * u[k];
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 3, output transform A^T m and bias
	////////////////////////////////////////////////////////////
	always_comb begin
		s0 = m[0] + m[1] + m[2];
		s1 = m[1] - m[2] - m[3];
		y0 = (s0 >>> 1) + signed'(bias_ext);  // Sums are even, halving is exact
		y1 = (s1 >>> 1) + signed'(bias_ext);
	end

	always_ff @(posedge clk) begin
		if (vld[1])
			outs <= {y1, y0};
	end

	assign out_valid = vld[PE_LATENCY-1];

endmodule

`default_nettype wire

// ==== kernel_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_buffer (
	input  logic                                                           clk,
	input  logic                                                           rst_n,
	input  logic                                                           kernel_we,
	input  logic [cnn_pkg::LANE_IDX_W-1:0]                                 kernel_lane,
	input  logic [cnn_pkg::KER_LEN*cnn_pkg::WEIGHT_W-1:0]                  kernel_taps,
	input  logic [cnn_pkg::BIAS_W-1:0]                                     kernel_bias,
	input  logic [cnn_pkg::SHIFT_W-1:0]                                    bias_shift,
	output logic [cnn_pkg::LANES*cnn_pkg::TILE_IN*cnn_pkg::TWEIGHT_W-1:0] tweights,
	output logic [cnn_pkg::LANES*cnn_pkg::RESULT_W-1:0]                   bias_ext
);

	import cnn_pkg::*;

	logic signed [WEIGHT_W-1:0]  g0, g1, g2;
	logic signed [TWEIGHT_W-1:0] u_new [TILE_IN];
	logic signed [TWEIGHT_W-1:0] u_mem [LANES][TILE_IN];
	logic signed [BIAS_W-1:0]    bias_mem [LANES];

	assign g0 = kernel_taps[0*WEIGHT_W +: WEIGHT_W];
	assign g1 = kernel_taps[1*WEIGHT_W +: WEIGHT_W];
	assign g2 = kernel_taps[2*WEIGHT_W +: WEIGHT_W];

	// 2*G*g keeps the half terms integral
	always_comb begin
		u_new[0] = g0 + g0;
		u_new[1] = g0 + g1 + g2;
		u_new[2] = g0 - g1 + g2;
		u_new[3] = g2 + g2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < LANES; l++) begin
				bias_mem[l] <= '0;
				for (int k = 0; k < TILE_IN; k++)
					u_mem[l][k] <= '0;
			end
		end else if (kernel_we) begin
			for (int l = 0; l < LANES; l++) begin
				if (kernel_lane == LANE_IDX_W'(l)) begin  // Out of range lane is dropped
					bias_mem[l] <= kernel_bias;
					for (int k = 0; k < TILE_IN; k++)
						u_mem[l][k] <= u_new[k];
				end
			end
		end
	end

	// Flatten per lane, bias widened then scaled
	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			for (int k = 0; k < TILE_IN; k++)
				tweights[(l*TILE_IN + k)*TWEIGHT_W +: TWEIGHT_W] = u_mem[l][k];
			bias_ext[l*RESULT_W +: RESULT_W] = RESULT_W'(bias_mem[l]) <<< bias_shift;
		end
	end

endmodule

`default_nettype wire

// ==== top_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module top_control (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic [cnn_pkg::INST_W-1:0]                    inst,
	input  logic                                          inst_empty,
	output logic                                          inst_req,
	output logic                                          kernel_we,
	output logic [cnn_pkg::LANE_IDX_W-1:0]                kernel_lane,
	output logic [cnn_pkg::KER_LEN*cnn_pkg::WEIGHT_W-1:0] kernel_taps,
	output logic [cnn_pkg::BIAS_W-1:0]                    kernel_bias,
	output logic [cnn_pkg::SHIFT_W-1:0]                   bias_shift,
	output cnn_pkg::pool_e                                pool_type
);

	import cnn_pkg::*;

	ctrl_state_e state, state_nxt;
	opcode_e     opcode;
	logic        mode_we;

	////////////////////////////////////////////////////////////
	// Fetch FSM, one word per three cycles
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (!inst_empty)
					state_nxt = ST_FETCH;
			end
			ST_FETCH:  state_nxt = ST_DECODE;  // Word shows up next cycle
			ST_DECODE: state_nxt = ST_IDLE;
			default:   state_nxt = ST_IDLE;
		endcase
	end

	assign inst_req = (state == ST_FETCH);  // Single pop pulse

	// Decode
	assign opcode      = opcode_e'(inst[OP_LSB +: OP_W]);
	assign kernel_lane = inst[LANE_LSB +: LANE_IDX_W];
	assign kernel_taps = inst[TAP_LSB +: KER_LEN*WEIGHT_W];
	assign kernel_bias = inst[BIAS_LSB +: BIAS_W];

	always_comb begin
		kernel_we = 1'b0;
		mode_we   = 1'b0;
		if (state == ST_DECODE) begin
			case (opcode)
				OP_LOAD_KERNEL: kernel_we = 1'b1;
				OP_SET_MODE:    mode_we   = 1'b1;
				OP_NOP:         ;
				default:        ;  // Unknown codes fall through as NOP
			endcase
		end
	end

	// Mode registers, held until the next mode word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pool_type  <= POOL_MAX;
			bias_shift <= '0;
		end else if (mode_we) begin
			pool_type  <= pool_e'(inst[POOL_BIT]);
			bias_shift <= inst[SHIFT_LSB +: SHIFT_W];
		end
	end

endmodule

`default_nettype wire

// ==== cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

	////////////////////////////////////////////////////////////
	// Datapath sizes
	////////////////////////////////////////////////////////////
	localparam int LANES      = 4;
	localparam int FEAT_W     = 8;   // Signed sample
	localparam int WEIGHT_W   = 8;   // Signed kernel tap
	localparam int TWEIGHT_W  = 10;  // Twice the transformed tap
	localparam int BIAS_W     = 20;
	localparam int SHIFT_W    = 5;
	localparam int RESULT_W   = 24;
	localparam int TILE_IN    = 4;   // Samples per lane per tile
	localparam int TILE_OUT   = 2;   // F(2,3) outputs
	localparam int KER_LEN    = 3;
	localparam int PE_LATENCY = 3;   // Lane pipeline depth

	////////////////////////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////////////////////////
	localparam int INST_W     = 64;
	localparam int OP_W       = 4;
	localparam int LANE_IDX_W = 4;
	localparam int OP_LSB     = 60;
	localparam int LANE_LSB   = 56;
	localparam int TAP_LSB    = 32;  // g0 in lowest byte
	localparam int BIAS_LSB   = 12;
	// Mode word only
	localparam int POOL_BIT   = 5;
	localparam int SHIFT_LSB  = 0;

	typedef enum logic [OP_W-1:0] {
		OP_NOP         = 4'd0,
		OP_LOAD_KERNEL = 4'd1,
		OP_SET_MODE    = 4'd2
	} opcode_e;

	typedef enum logic {
		POOL_MAX = 1'b0,
		POOL_AVG = 1'b1
	} pool_e;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_FETCH  = 2'd1,
		ST_DECODE = 2'd2
	} ctrl_state_e;

endpackage

`default_nettype wire
